// File: logic/raster_pkg.sv
`default_nettype none

package raster_pkg;

    // screen coordinates, whole pixels
    typedef logic [10:0] coord_t;

    typedef logic [15:0] depth_t;

    // red 23..16, green 15..8, blue 7..0
    typedef logic [23:0] rgb_t;

    typedef logic [25:0] fb_addr_t;   // frame buffer word address

    // edge functions and area; 24 bits covers coordinate products up to 2047
    typedef logic signed [23:0] edge_t;

    // weight times attribute, summed over three vertices
    typedef logic [39:0] sum_t;

    localparam int color_channels = 3;

    typedef enum logic [1:0] {
        walk_idle,
        walk_scan,
        walk_frame_end
    } walk_state_t;

    // E_ab(x, y) = (x - xa)(yb - ya) - (y - ya)(xb - xa)
    function automatic edge_t edge_fn(
        input coord_t xa,
        input coord_t ya,
        input coord_t xb,
        input coord_t yb,
        input coord_t x,
        input coord_t y
    );
        logic signed [11:0] dx;
        logic signed [11:0] dy;
        logic signed [11:0] ex;
        logic signed [11:0] ey;
        dx = $signed({1'b0, x}) - $signed({1'b0, xa});
        dy = $signed({1'b0, y}) - $signed({1'b0, ya});
        ex = $signed({1'b0, xb}) - $signed({1'b0, xa});
        ey = $signed({1'b0, yb}) - $signed({1'b0, ya});
        edge_fn = dx * ey - dy * ex;   // both products sign-extend to 24 bits
    endfunction

endpackage

`default_nettype wire

// File: logic/raster_ifs.sv
`timescale 1ns/100ps
`default_nettype none

// one set-up triangle, from setup to walker
interface tri_setup_if import raster_pkg::*; ();
    logic valid;
    logic ready;
    coord_t x1, y1, x2, y2, x3, y3;
    coord_t min_x, max_x, min_y, max_y;   // clipped box
    edge_t area;
    rgb_t color1, color2, color3;
    depth_t z1, z2, z3;
    fb_addr_t base_addr;
    logic frame_last;
    logic empty;   // nothing to scan

    modport source (
        output valid, x1, y1, x2, y2, x3, y3, min_x, max_x, min_y, max_y,
        output area, color1, color2, color3, z1, z2, z3, base_addr, frame_last, empty,
        input ready
    );

    modport sink (
        input valid, x1, y1, x2, y2, x3, y3, min_x, max_x, min_y, max_y,
        input area, color1, color2, color3, z1, z2, z3, base_addr, frame_last, empty,
        output ready
    );
endinterface

// covered pixels from walker to shader
interface fragment_if import raster_pkg::*; ();
    logic valid;
    logic ready;
    coord_t x, y;
    edge_t w1, w2, w3;
    logic frame_end;   // marker only, no pixel
    // per-triangle attributes, constant while the triangle is walked
    edge_t area;
    rgb_t color1, color2, color3;
    depth_t z1, z2, z3;
    fb_addr_t base_addr;

    modport source (
        output valid, x, y, w1, w2, w3, frame_end,
        output area, color1, color2, color3, z1, z2, z3, base_addr,
        input ready
    );

    modport sink (
        input valid, x, y, w1, w2, w3, frame_end,
        input area, color1, color2, color3, z1, z2, z3, base_addr,
        output ready
    );
endinterface

`default_nettype wire

// File: logic/triangle_setup.sv
`timescale 1ns/100ps
`default_nettype none

module triangle_setup import raster_pkg::*; #(
    parameter int screen_width  = 640,
    parameter int screen_height = 480
) (
    input wire clock,
    input wire reset,
    input wire coord_t x1, y1,
    input wire depth_t z1,
    input wire rgb_t color1,
    input wire coord_t x2, y2,
    input wire depth_t z2,
    input wire rgb_t color2,
    input wire coord_t x3, y3,
    input wire depth_t z3,
    input wire rgb_t color3,
    input wire fb_addr_t base_addr,
    input wire frame_last,
    input wire in_valid,
    output logic in_ready,
    tri_setup_if.source setup
);

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        min3 = (c < m) ? c : m;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        max3 = (c > m) ? c : m;
    endfunction

    // clamp to the last pixel of the axis
    function automatic coord_t clip(input coord_t v, input int limit);
        clip = (v > coord_t'(limit - 1)) ? coord_t'(limit - 1) : v;
    endfunction

    coord_t lo_x, hi_x, lo_y, hi_y;
    edge_t area_c;
    logic take;
    logic running;

    assign lo_x = min3(x1, x2, x3);
    assign hi_x = max3(x1, x2, x3);
    assign lo_y = min3(y1, y2, y3);
    assign hi_y = max3(y1, y2, y3);
    assign area_c = edge_fn(x1, y1, x2, y2, x3, y3);   // E_12 at v3

    assign in_ready = running && (!setup.valid || setup.ready);
    assign take = in_valid && in_ready;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            running <= 1'b0;
            setup.valid <= 1'b0;
        end else begin
            running <= 1'b1;   // first cycle out of reset takes nothing
            if (take)
                setup.valid <= 1'b1;
            else if (setup.ready)
                setup.valid <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            setup.x1 <= x1;
            setup.y1 <= y1;
            setup.x2 <= x2;
            setup.y2 <= y2;
            setup.x3 <= x3;
            setup.y3 <= y3;
            setup.min_x <= clip(lo_x, screen_width);
            setup.max_x <= clip(hi_x, screen_width);
            setup.min_y <= clip(lo_y, screen_height);
            setup.max_y <= clip(hi_y, screen_height);
            setup.area <= area_c;
            // clockwise, degenerate, or entirely off the right or bottom edge
            setup.empty <= !(area_c > 0) || lo_x >= coord_t'(screen_width)
                           || lo_y >= coord_t'(screen_height);
            setup.color1 <= color1;
            setup.color2 <= color2;
            setup.color3 <= color3;
            setup.z1 <= z1;
            setup.z2 <= z2;
            setup.z3 <= z3;
            setup.base_addr <= base_addr;
            setup.frame_last <= frame_last;
        end
    end

endmodule

`default_nettype wire

// File: logic/pixel_walker.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_walker import raster_pkg::*; (
    input wire clock,
    input wire reset,
    tri_setup_if.sink setup,
    fragment_if.source frag
);

    walk_state_t state;
    coord_t vx1, vy1, vx2, vy2, vx3, vy3;
    coord_t min_x, max_x, max_y;
    logic last_flag;
    coord_t cur_x, cur_y;
    edge_t e12, e23, e31;
    logic covered;
    logic out_free;
    logic row_end, box_end;
    logic take;

    assign e23 = edge_fn(vx2, vy2, vx3, vy3, cur_x, cur_y);
    assign e31 = edge_fn(vx3, vy3, vx1, vy1, cur_x, cur_y);
    assign e12 = edge_fn(vx1, vy1, vx2, vy2, cur_x, cur_y);
    assign covered = e12 >= 0 && e23 >= 0 && e31 >= 0;

    assign out_free = !frag.valid || frag.ready;   // output register empty or leaving
    assign row_end = cur_x == max_x;
    assign box_end = row_end && cur_y == max_y;

    // next triangle only once the last item has gone out
    assign setup.ready = state == walk_idle && out_free;
    assign take = setup.valid && setup.ready;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= walk_idle;
            frag.valid <= 1'b0;
        end else begin
            if (out_free)
                frag.valid <= (state == walk_scan && covered) || state == walk_frame_end;
            case (state)
                walk_idle: begin
                    if (take && !setup.empty)
                        state <= walk_scan;
                    else if (take && setup.frame_last)
                        state <= walk_frame_end;   // dropped but still ends the frame
                end
                walk_scan: begin
                    if (out_free && box_end)
                        state <= last_flag ? walk_frame_end : walk_idle;
                end
                walk_frame_end: begin
                    if (out_free)
                        state <= walk_idle;
                end
                default: state <= walk_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            vx1 <= setup.x1;
            vy1 <= setup.y1;
            vx2 <= setup.x2;
            vy2 <= setup.y2;
            vx3 <= setup.x3;
            vy3 <= setup.y3;
            min_x <= setup.min_x;
            max_x <= setup.max_x;
            max_y <= setup.max_y;
            last_flag <= setup.frame_last;
            cur_x <= setup.min_x;
            cur_y <= setup.min_y;
            frag.area <= setup.area;
            frag.color1 <= setup.color1;
            frag.color2 <= setup.color2;
            frag.color3 <= setup.color3;
            frag.z1 <= setup.z1;
            frag.z2 <= setup.z2;
            frag.z3 <= setup.z3;
            frag.base_addr <= setup.base_addr;
        end else if (state == walk_scan && out_free) begin
            if (row_end) begin
                cur_x <= min_x;
                cur_y <= cur_y + 1'b1;
            end else begin
                cur_x <= cur_x + 1'b1;
            end
        end
        if (out_free) begin
            frag.x <= cur_x;
            frag.y <= cur_y;
            frag.w1 <= e23;
            frag.w2 <= e31;
            frag.w3 <= e12;
            frag.frame_end <= state == walk_frame_end;
        end
    end

endmodule

`default_nettype wire

// File: logic/fragment_shader.sv
`timescale 1ns/100ps
`default_nettype none

module fragment_shader import raster_pkg::*; #(
    parameter int screen_width = 640
) (
    input wire clock,
    input wire reset,
    fragment_if.sink frag,
    input wire out_ready,
    output logic out_valid,
    output fb_addr_t addr,
    output rgb_t color,
    output depth_t depth,
    output logic frame_done
);

    // weights of covered pixels are never negative, so the sign bit is dropped
    localparam int weight_bits = $bits(edge_t) - 1;
    typedef logic [weight_bits-1:0] weight_t;

    function automatic sum_t wsum(
        input edge_t wa,
        input edge_t wb,
        input edge_t wc,
        input logic [15:0] va,
        input logic [15:0] vb,
        input logic [15:0] vc
    );
        wsum = sum_t'(weight_t'(wa)) * va + sum_t'(weight_t'(wb)) * vb
             + sum_t'(weight_t'(wc)) * vc;
    endfunction

    logic advance;
    logic s1_valid, s1_end;
    logic s2_valid, s2_end;
    sum_t csum [color_channels];
    sum_t s1_csum [color_channels];
    sum_t s1_zsum;
    fb_addr_t s1_addr;
    weight_t s1_area;

    // a marker in stage 2 always leaves, a fragment needs out_ready
    assign advance = !s2_valid || s2_end || out_ready;
    assign frag.ready = advance;

    always_comb begin
        for (int ch = 0; ch < color_channels; ch++)
            csum[ch] = wsum(frag.w1, frag.w2, frag.w3, frag.color1[ch*8 +: 8],
                            frag.color2[ch*8 +: 8], frag.color3[ch*8 +: 8]);
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            s1_valid <= 1'b0;
            s1_end <= 1'b0;
            s2_valid <= 1'b0;
            s2_end <= 1'b0;
        end else if (advance) begin
            s1_valid <= frag.valid;
            s1_end <= frag.frame_end;
            s2_valid <= s1_valid;
            s2_end <= s1_end;
        end
    end

    // stage 1: weighted sums and address, stage 2: divide by area
    always_ff @(posedge clock) begin
        if (advance) begin
            s1_csum <= csum;
            s1_zsum <= wsum(frag.w1, frag.w2, frag.w3, frag.z1, frag.z2, frag.z3);
            s1_addr <= frag.base_addr + fb_addr_t'(frag.y) * fb_addr_t'(screen_width)
                       + fb_addr_t'(frag.x);
            s1_area <= frag.frame_end ? weight_t'(1) : weight_t'(frag.area);   // marker divides by 1
            addr <= s1_addr;
            for (int ch = 0; ch < color_channels; ch++)
                color[ch*8 +: 8] <= 8'(s1_csum[ch] / s1_area);
            depth <= depth_t'(s1_zsum / s1_area);
        end
    end

    assign out_valid = s2_valid && !s2_end;
    assign frame_done = s2_valid && s2_end;

endmodule

`default_nettype wire

// File: logic/rasterizer.sv
`timescale 1ns/100ps
`default_nettype none

module rasterizer import raster_pkg::*; #(
    parameter int screen_width  = 640,
    parameter int screen_height = 480
) (
    input wire clock,
    input wire reset,
    input wire coord_t x1, y1,
    input wire depth_t z1,
    input wire rgb_t color1,
    input wire coord_t x2, y2,
    input wire depth_t z2,
    input wire rgb_t color2,
    input wire coord_t x3, y3,
    input wire depth_t z3,
    input wire rgb_t color3,
    input wire fb_addr_t base_addr,
    input wire frame_last,
    input wire in_valid,
    output logic in_ready,
    input wire out_ready,
    output logic out_valid,
    output fb_addr_t addr,
    output rgb_t color,
    output depth_t depth,
    output logic frame_done
);

    tri_setup_if setup_bus ();
    fragment_if frag_bus ();

    triangle_setup #(
        .screen_width (screen_width),
        .screen_height(screen_height)
    ) setup_i (
        .clock     (clock),
        .reset     (reset),
        .x1        (x1),
        .y1        (y1),
        .z1        (z1),
        .color1    (color1),
        .x2        (x2),
        .y2        (y2),
        .z2        (z2),
        .color2    (color2),
        .x3        (x3),
        .y3        (y3),
        .z3        (z3),
        .color3    (color3),
        .base_addr (base_addr),
        .frame_last(frame_last),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .setup     (setup_bus.source)
    );

    pixel_walker walker_i (
        .clock(clock),
        .reset(reset),
        .setup(setup_bus.sink),
        .frag (frag_bus.source)
    );

    fragment_shader #(
        .screen_width(screen_width)
    ) shader_i (
        .clock     (clock),
        .reset     (reset),
        .frag      (frag_bus.sink),
        .out_ready (out_ready),
        .out_valid (out_valid),
        .addr      (addr),
        .color     (color),
        .depth     (depth),
        .frame_done(frame_done)
    );

endmodule

`default_nettype wire

// File: dv/rasterizer_checker.sv
`timescale 1ns/100ps
`default_nettype none

module rasterizer_checker import raster_pkg::*; (
    input wire clock,
    input wire reset,
    input wire out_valid,
    input wire out_ready,
    input wire fb_addr_t addr,
    input wire rgb_t color,
    input wire depth_t depth,
    input wire frame_done
);

    // a stalled fragment keeps its place and its data
    hold_under_stall: assert property (@(posedge clock) disable iff (!reset)
        out_valid && !out_ready |=> out_valid && $stable({addr, color, depth}))
        else $error("output fragment changed while stalled");

    // frame_done is a lone pulse, never beside a fragment
    done_apart: assert property (@(posedge clock) disable iff (!reset)
        frame_done |-> !out_valid && !$past(frame_done))
        else $error("frame_done overlapped out_valid or lasted more than one cycle");

    // first edge after release
    quiet_after_reset: assert property (@(posedge clock)
        $rose(reset) |-> !out_valid)
        else $error("out_valid high right after reset");

endmodule

bind rasterizer rasterizer_checker chk_i (.*);

`default_nettype wire

// File: dv/rasterizer_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rasterizer_tb import raster_pkg::*; ;

    localparam int n_tests = 45;
    localparam int width = 640;
    localparam int height = 480;

    logic clock, reset;
    coord_t x1, y1, x2, y2, x3, y3;
    depth_t z1, z2, z3;
    rgb_t color1, color2, color3;
    fb_addr_t base_addr;
    logic frame_last, in_valid, in_ready, out_ready, out_valid, frame_done;
    fb_addr_t addr;
    rgb_t color;
    depth_t depth;

    int tv_x[n_tests][3], tv_y[n_tests][3], tv_z[n_tests][3];
    logic [23:0] tv_c[n_tests][3];
    logic [25:0] tv_base[n_tests];
    logic tv_last[n_tests];
    string tv_name[n_tests];
    logic [66:0] exp_q[$];   // {is_done, addr, color, depth}
    int exp_tag[$];
    int exp_count[n_tests], got_count[n_tests], test_errors[n_tests];
    int errors = 0, matched = 0, reported = 0;
    longint total_box = 0;
    logic [31:0] lfsr_state = 32'hb8c4_366d;
    bit driving_done = 0;

    rasterizer dut_i (.*);

    initial begin
        clock = 0;
        forever #10 clock = ~clock;
    end

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int edge_val(int xa, int ya, int xb, int yb, int x, int y);
        return (x - xa) * (yb - ya) - (y - ya) * (xb - xa);
    endfunction

    // expected {color, depth} of one covered pixel
    function automatic logic [39:0] shade_pixel(int k, int x, int y, int area);
        int w[3];
        longint s;
        logic [39:0] r;
        w[0] = edge_val(tv_x[k][1], tv_y[k][1], tv_x[k][2], tv_y[k][2], x, y);
        w[1] = edge_val(tv_x[k][2], tv_y[k][2], tv_x[k][0], tv_y[k][0], x, y);
        w[2] = edge_val(tv_x[k][0], tv_y[k][0], tv_x[k][1], tv_y[k][1], x, y);
        for (int ch = 0; ch < 3; ch++) begin
            s = 0;
            for (int i = 0; i < 3; i++)
                s += longint'(w[i]) * tv_c[k][i][ch*8 +: 8];
            r[16 + ch*8 +: 8] = 8'(s / area);
        end
        s = 0;
        for (int i = 0; i < 3; i++)
            s += longint'(w[i]) * tv_z[k][i];
        r[15:0] = 16'(s / area);
        return r;
    endfunction

    task automatic model_triangle(int k);
        int area, lx, hx, ly, hy;
        logic [25:0] a;
        area = edge_val(tv_x[k][0], tv_y[k][0], tv_x[k][1], tv_y[k][1], tv_x[k][2], tv_y[k][2]);
        lx = tv_x[k][0] < tv_x[k][1] ? tv_x[k][0] : tv_x[k][1];
        lx = tv_x[k][2] < lx ? tv_x[k][2] : lx;
        hx = tv_x[k][0] > tv_x[k][1] ? tv_x[k][0] : tv_x[k][1];
        hx = tv_x[k][2] > hx ? tv_x[k][2] : hx;
        ly = tv_y[k][0] < tv_y[k][1] ? tv_y[k][0] : tv_y[k][1];
        ly = tv_y[k][2] < ly ? tv_y[k][2] : ly;
        hy = tv_y[k][0] > tv_y[k][1] ? tv_y[k][0] : tv_y[k][1];
        hy = tv_y[k][2] > hy ? tv_y[k][2] : hy;
        if (hx > width - 1) hx = width - 1;
        if (hy > height - 1) hy = height - 1;
        if (hx >= lx && hy >= ly) total_box += (hx - lx + 1) * (hy - ly + 1);
        if (area > 0 && lx < width && ly < height) begin
            for (int y = ly; y <= hy; y++)
                for (int x = lx; x <= hx; x++)
                    if (edge_val(tv_x[k][0], tv_y[k][0], tv_x[k][1], tv_y[k][1], x, y) >= 0
                        && edge_val(tv_x[k][1], tv_y[k][1], tv_x[k][2], tv_y[k][2], x, y) >= 0
                        && edge_val(tv_x[k][2], tv_y[k][2], tv_x[k][0], tv_y[k][0], x, y) >= 0)
                    begin
                        a = tv_base[k] + 26'(y * width + x);
                        exp_q.push_back({1'b0, a, shade_pixel(k, x, y, area)});
                        exp_tag.push_back(k);
                        exp_count[k]++;
                    end
        end
        if (tv_last[k]) begin
            exp_q.push_back({1'b1, 66'b0});
            exp_tag.push_back(k);
            exp_count[k]++;
        end
    endtask

    task automatic set_vertex(int k, int i, int x, int y, int z, logic [23:0] c);
        tv_x[k][i] = x;
        tv_y[k][i] = y;
        tv_z[k][i] = z;
        tv_c[k][i] = c;
    endtask

    task automatic build_tests();
        int bx, by;
        set_vertex(0, 0, 10, 10, 500, 24'h336699);
        set_vertex(0, 1, 10, 20, 500, 24'h336699);
        set_vertex(0, 2, 20, 10, 500, 24'h336699);
        set_vertex(1, 0, 100, 50, 1000, 24'hff0000);
        set_vertex(1, 1, 104, 70, 40000, 24'h00ff00);
        set_vertex(1, 2, 130, 60, 65535, 24'h0000ff);
        set_vertex(2, 0, 100, 50, 1, 24'h123456);   // clockwise
        set_vertex(2, 1, 130, 60, 2, 24'h123456);
        set_vertex(2, 2, 104, 70, 3, 24'h123456);
        set_vertex(3, 0, 5, 5, 7, 24'habcdef);      // collinear
        set_vertex(3, 1, 10, 10, 7, 24'habcdef);
        set_vertex(3, 2, 15, 15, 7, 24'habcdef);
        set_vertex(4, 0, 600, 440, 100, 24'h804020);
        set_vertex(4, 1, 600, 500, 9000, 24'h20ff40);
        set_vertex(4, 2, 700, 440, 30000, 24'h0010ff);
        tv_name[0] = "flat";
        tv_name[1] = "interp";
        tv_name[2] = "reject_cw";
        tv_name[3] = "reject_line";
        tv_name[4] = "clip";
        tv_base[0] = 26'h0;
        tv_base[1] = 26'h10000;
        tv_base[2] = 26'h0;
        tv_base[3] = 26'h0;
        tv_base[4] = 26'h200000;
        tv_last[0] = 1;
        tv_last[1] = 0;
        tv_last[2] = 0;
        tv_last[3] = 1;
        tv_last[4] = 1;
        for (int k = 5; k < n_tests; k++) begin
            bx = rand_bits(10) % 600;
            by = rand_bits(9) % 440;
            for (int i = 0; i < 3; i++)
                set_vertex(k, i, bx + rand_bits(5), by + rand_bits(5), rand_bits(16),
                           24'(rand_bits(24)));
            tv_base[k] = 26'(rand_bits(20));
            tv_last[k] = rand_bits(1) || k == n_tests - 1;
            tv_name[k] = "random";
        end
    endtask

    task automatic drive_triangles();
        @(negedge clock);
        for (int k = 0; k < n_tests; k++) begin
            {x1, y1, z1, color1} = {11'(tv_x[k][0]), 11'(tv_y[k][0]), 16'(tv_z[k][0]), tv_c[k][0]};
            {x2, y2, z2, color2} = {11'(tv_x[k][1]), 11'(tv_y[k][1]), 16'(tv_z[k][1]), tv_c[k][1]};
            {x3, y3, z3, color3} = {11'(tv_x[k][2]), 11'(tv_y[k][2]), 16'(tv_z[k][2]), tv_c[k][2]};
            base_addr = tv_base[k];
            frame_last = tv_last[k];
            in_valid = 1;
            #1;   // in_ready follows out_ready, which also changes on this edge
            while (!in_ready) begin
                @(negedge clock);
                #1;
            end
            @(negedge clock);   // taken on the edge in between
        end
        in_valid = 0;
        driving_done = 1;
    endtask

    task automatic note_item(int tag);
        got_count[tag]++;
        while (reported < n_tests && got_count[reported] == exp_count[reported]) begin
            $display("test %0d %s: %0d items, %0d errors", reported, tv_name[reported],
                     got_count[reported], test_errors[reported]);
            reported++;
        end
    endtask

    // out_ready is chosen here so a transfer is known before its edge
    task automatic compare_outputs();
        logic [66:0] item;
        int tag;
        forever begin
            @(negedge clock);
            out_ready = rand_bits(2) != 0;
            if ((out_valid && out_ready) || frame_done) begin
                assert (exp_q.size() > 0) else begin
                    $display("unexpected output after the last expected item");
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    item = exp_q.pop_front();
                    tag = exp_tag.pop_front();
                    assert (item[66] == frame_done) else begin
                        $display("[ERROR] %s expected %s actual %s", tv_name[tag],
                                 item[66] ? "frame_done" : "fragment",
                                 frame_done ? "frame_done" : "fragment");
                        errors++;
                        test_errors[tag]++;
                    end
                    assert (frame_done || item[65:0] == {addr, color, depth}) else begin
                        $display("[ERROR] %s expected %h actual %h", tv_name[tag], item[65:0],
                                 {addr, color, depth});
                        errors++;
                        test_errors[tag]++;
                    end
                    matched++;
                    note_item(tag);
                end
            end
        end
    endtask

    initial begin
        int limit;
        reset = 0;
        in_valid = 0;
        out_ready = 0;
        frame_last = 0;
        base_addr = 0;
        {x1, y1, z1, color1, x2, y2, z2, color2, x3, y3, z3, color3} = '0;
        build_tests();
        for (int k = 0; k < n_tests; k++)
            model_triangle(k);
        limit = int'(total_box) * 8 + n_tests * 200 + 1000;
        repeat (16) @(negedge clock);
        reset = 1;
        fork
            drive_triangles();
            compare_outputs();
            begin
                repeat (limit) @(negedge clock);
                $display("watchdog expired after %0d cycles with %0d items outstanding",
                         limit, exp_q.size());
                $display("TB FAILED");
                $finish;
            end
        join_none
        while (!(driving_done && exp_q.size() == 0)) @(negedge clock);
        repeat (50) @(negedge clock);   // catch anything extra
        $display("summary: %0d tests, %0d items matched, %0d errors", reported, matched, errors);
        if (errors == 0 && reported == n_tests)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
logic/raster_pkg.sv
logic/raster_ifs.sv
logic/triangle_setup.sv
logic/pixel_walker.sv
logic/fragment_shader.sv
logic/rasterizer.sv
dv/rasterizer_checker.sv
dv/rasterizer_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the rasterizer testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rasterizer_tb -f files.f -o rasterizer_sim

./obj_dir/rasterizer_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
    exit 1
fi
exit 0
